// ==== Makefile ====
TOP = decode_stage_tb
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
hw/idu_pkg.sv
hw/inst_buffer.sv
hw/inst_decoder.sv
hw/dispatcher.sv
hw/decode_stage.sv
testbench/tb_clock_gen.sv
testbench/decode_stage_props.sv
testbench/decode_stage_tb.sv

// ==== hw/decode_stage.sv ====
//////////////////////////////
// Decode stage top level.
// Fetch pairs enter under credit flow control and
// leave as one issue record per lane.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module decode_stage
	import idu_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                fetch_valid,
	input  fetch_pair_t         fetch,
	output logic [CREDIT_W-1:0] credit_return,
	input  logic                flush,
	output issue_t [LANES-1:0]  issue
);

	logic                 head_vld;
	fetch_pair_t          head;
	logic                 lane0_done;
	logic [LANES-1:0]     issue_mask;
	decoded_t [LANES-1:0] dec;

	inst_buffer i_inst_buffer (
		.clk           (clk),
		.rst_n         (rst_n),
		.fetch_valid   (fetch_valid),
		.fetch         (fetch),
		.flush         (flush),
		.issue_mask    (issue_mask),
		.head_vld      (head_vld),
		.head          (head),
		.lane0_done    (lane0_done),
		.credit_return (credit_return)
	);

	for (genvar i = 0; i < LANES; i++) begin : g_dec
		inst_decoder #(
			.LANE (i)
		) i_inst_decoder (
			.head (head),
			.dec  (dec[i])
		);
	end

	dispatcher i_dispatcher (
		.clk        (clk),
		.rst_n      (rst_n),
		.head_vld   (head_vld),
		.lane0_done (lane0_done),
		.dec        (dec),
		.flush      (flush),
		.issue_mask (issue_mask),
		.issue      (issue)
	);

endmodule

`default_nettype wire

// ==== hw/dispatcher.sv ====
//////////////////////////////
// Dual-issue dispatcher.
// Picks which lanes of the head pair go to execute,
// feeds the mask back to the buffer and registers
// the issued lanes for the execute stage.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dispatcher
	import idu_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   head_vld,
	input  logic                   lane0_done,
	input  decoded_t [LANES-1:0]   dec,
	input  logic                   flush,
	output logic [LANES-1:0]       issue_mask,
	output issue_t [LANES-1:0]     issue
);

	logic                 go;
	logic                 raw_dep;
	logic                 hold_lane1;
	issue_t [LANES-1:0]   pay_q;

	assign go = head_vld && !flush;

	// Lane 1 reads what lane 0 writes
	assign raw_dep = dec[0].rd_vld &&
		((dec[1].rs1_vld && dec[1].rs1 == dec[0].rd) ||
		 (dec[1].rs2_vld && dec[1].rs2 == dec[0].rd));

	assign hold_lane1 = dec[0].illegal || raw_dep;

	assign issue_mask[0] = go && !lane0_done;
	assign issue_mask[1] = go && (lane0_done || !hold_lane1);

	// Payload holds the last issued lane, valid is updated every cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pay_q <= '0;
		end else begin
			for (int i = 0; i < LANES; i++) begin
				pay_q[i].valid <= issue_mask[i];
				if (issue_mask[i]) begin
					pay_q[i].pc        <= dec[i].pc;
					pay_q[i].op        <= dec[i].op;
					pay_q[i].rd        <= dec[i].rd;
					pay_q[i].rd_vld    <= dec[i].rd_vld;
					pay_q[i].rs1       <= dec[i].rs1;
					pay_q[i].rs2       <= dec[i].rs2;
					pay_q[i].imm       <= dec[i].imm;
					pay_q[i].exception <= dec[i].illegal;
				end
			end
		end
	end

	assign issue = pay_q;

endmodule

`default_nettype wire

// ==== hw/idu_pkg.sv ====
//////////////////////////////
// Shared widths, opcodes and record types of the
// dual-issue RV32I decode stage. Imported by every module.
//////////////////////////////
`default_nettype none

package idu_pkg;

	localparam int XLEN      = 32;
	localparam int LANES     = 2;
	localparam int REG_IDX_W = 5;
	localparam int BUF_DEPTH = 4;
	localparam int CREDIT_W  = 3;
	localparam int PTR_W     = $clog2(BUF_DEPTH);

	// RV32I major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	typedef enum logic [2:0] {
		OP_ALU,
		OP_LUI,
		OP_AUIPC,
		OP_JAL,
		OP_JALR,
		OP_BRANCH,
		OP_LOAD,
		OP_STORE
	} op_class_t;

	// Lane 1 sits at pc + 4
	typedef struct packed {
		logic [XLEN-1:0]            pc;
		logic [LANES-1:0][XLEN-1:0] inst;
	} fetch_pair_t;

	typedef struct packed {
		logic [XLEN-1:0]      pc;
		op_class_t            op;
		logic [REG_IDX_W-1:0] rd;
		logic                 rd_vld;
		logic [REG_IDX_W-1:0] rs1;
		logic                 rs1_vld;
		logic [REG_IDX_W-1:0] rs2;
		logic                 rs2_vld;
		logic [XLEN-1:0]      imm;
		logic                 illegal;
	} decoded_t;

	typedef struct packed {
		logic                 valid;
		logic [XLEN-1:0]      pc;
		op_class_t            op;
		logic [REG_IDX_W-1:0] rd;
		logic                 rd_vld;
		logic [REG_IDX_W-1:0] rs1;
		logic [REG_IDX_W-1:0] rs2;
		logic [XLEN-1:0]      imm;
		logic                 exception;
	} issue_t;

endpackage

`default_nettype wire

// ==== hw/inst_buffer.sv ====
//////////////////////////////
// Instruction buffer between fetch and decode.
// Holds fetch pairs, returns a credit per entry popped
// or flushed, and tracks a head pair split across cycles.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module inst_buffer
	import idu_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                fetch_valid,
	input  fetch_pair_t         fetch,
	input  logic                flush,
	input  logic [LANES-1:0]    issue_mask,
	output logic                head_vld,
	output fetch_pair_t         head,
	output logic                lane0_done,
	output logic [CREDIT_W-1:0] credit_return
);

	fetch_pair_t         mem [BUF_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CREDIT_W-1:0] count;
	logic [LANES-1:0]    need_mask;
	logic                push;
	logic                pop;

	assign head_vld = (count != '0);
	assign head     = mem[rd_ptr];

	// Lanes still owed by the head entry
	assign need_mask = lane0_done ? 2'b10 : 2'b11;
	assign pop       = head_vld && ((issue_mask & need_mask) == need_mask);
	assign push      = fetch_valid && !flush;

	// A pair arriving with flush is dropped too, so its credit goes back
	assign credit_return = flush ? count + CREDIT_W'(fetch_valid) : CREDIT_W'(pop);

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= fetch;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			lane0_done <= 1'b0;
		end else if (flush) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			lane0_done <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr     <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				lane0_done <= 1'b0;
			end else if (head_vld && !lane0_done && issue_mask == 2'b01) begin
				// Lane 1 held back, decode it again next cycle
				lane0_done <= 1'b1;
			end
			count <= count + CREDIT_W'(push) - CREDIT_W'(pop);
		end
	end

endmodule

`default_nettype wire

// ==== hw/inst_decoder.sv ====
//////////////////////////////
// RV32I decoder for one issue lane.
// Purely combinational; LANE picks the instruction
// out of the head pair and the PC offset.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module inst_decoder
	import idu_pkg::*;
#(
	parameter int LANE = 0
) (
	input  fetch_pair_t head,
	output decoded_t    dec
);

	logic [XLEN-1:0] inst;
	logic [6:0]      opcode;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	assign inst   = head.inst[LANE];
	assign opcode = inst[6:0];

	// Immediate formats, sign bit is always inst[31]
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec         = '0;
		dec.pc      = head.pc + XLEN'(4 * LANE);
		dec.op      = OP_ALU;
		dec.rd      = inst[11:7];
		dec.rs1     = inst[19:15];
		dec.rs2     = inst[24:20];
		case (opcode)
			OPC_LUI, OPC_AUIPC: begin
				dec.op     = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
				dec.rd_vld = 1'b1;
				dec.imm    = imm_u;
			end
			OPC_JAL: begin
				dec.op     = OP_JAL;
				dec.rd_vld = 1'b1;
				dec.imm    = imm_j;
			end
			OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
				if (opcode == OPC_JALR) begin
					dec.op = OP_JALR;
				end else if (opcode == OPC_LOAD) begin
					dec.op = OP_LOAD;
				end
				dec.rd_vld  = 1'b1;
				dec.rs1_vld = 1'b1;
				dec.imm     = imm_i;
			end
			OPC_BRANCH: begin
				dec.op      = OP_BRANCH;
				dec.rs1_vld = 1'b1;
				dec.rs2_vld = 1'b1;
				dec.imm     = imm_b;
			end
			OPC_STORE: begin
				dec.op      = OP_STORE;
				dec.rs1_vld = 1'b1;
				dec.rs2_vld = 1'b1;
				dec.imm     = imm_s;
			end
			OPC_OP: begin
				dec.rd_vld  = 1'b1;
				dec.rs1_vld = 1'b1;
				dec.rs2_vld = 1'b1;
			end
			default: begin
				dec.illegal = 1'b1;
			end
		endcase
		// Writes to x0 are discarded
		if (dec.rd == '0) begin
			dec.rd_vld = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/decode_stage_props.sv ====
//////////////////////////////
// Concurrent checks on the buffer and the dispatcher.
// Bound into both modules below.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module decode_stage_props
	import idu_pkg::*;
#(
	parameter bit CHECK_BUFFER = 1'b1
) (
	input logic                clk,
	input logic                rst_n,
	input logic                flush,
	input logic                fetch_valid,
	input logic [CREDIT_W-1:0] occupancy,
	input logic [LANES-1:0]    issue_vld
);

	if (CHECK_BUFFER) begin : g_buf
		a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
			occupancy <= CREDIT_W'(BUF_DEPTH))
			else $error("buffer occupancy above its depth");

		a_no_fetch_when_full: assert property (@(posedge clk) disable iff (!rst_n)
			fetch_valid |-> occupancy != CREDIT_W'(BUF_DEPTH))
			else $error("fetch pair sent into a full buffer");
	end else begin : g_disp
		// Nothing leaves decode right after a flush
		a_quiet_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
			flush |=> issue_vld == '0)
			else $error("lane issued in the cycle after flush");
	end

endmodule

bind inst_buffer decode_stage_props #(
	.CHECK_BUFFER (1'b1)
) i_buf_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.flush       (flush),
	.fetch_valid (fetch_valid),
	.occupancy   (count),
	.issue_vld   (2'b00)
);

bind dispatcher decode_stage_props #(
	.CHECK_BUFFER (1'b0)
) i_disp_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.flush       (flush),
	.fetch_valid (1'b0),
	.occupancy   ('0),
	.issue_vld   ({issue[1].valid, issue[0].valid})
);

`default_nettype wire

// ==== testbench/decode_stage_tb.sv ====
//////////////////////////////
// Directed testbench for the decode stage.
// Plays the fetch unit with a credit counter and checks
// every issued lane against an in-order expected queue.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb
	import idu_pkg::*;
();

	localparam int LIMIT = 200;
	localparam logic [6:0] OPC_TAB [10] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
		OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, 7'h7f};

	logic                clk;
	logic                rst_n;
	logic                fetch_valid;
	fetch_pair_t         fetch;
	logic                flush;
	logic [CREDIT_W-1:0] credit_return;
	issue_t [LANES-1:0]  issue;

	int          credits;
	int          flush_credits;
	int          errors;
	int          err_at_start;
	int          tests;
	string       test_name;
	logic [31:0] rng;
	issue_t      exp_q[$];
	logic        pair_q[$];

	tb_clock_gen i_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	decode_stage i_decode_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.fetch_valid   (fetch_valid),
		.fetch         (fetch),
		.credit_return (credit_return),
		.flush         (flush),
		.issue         (issue)
	);

	// Fetch-side credit counter
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits       <= BUF_DEPTH;
			flush_credits <= 0;
		end else begin
			credits <= credits + int'(credit_return) - int'(fetch_valid);
			if (flush) begin
				flush_credits <= int'(credit_return);
			end
		end
	end

	always @(negedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < LANES; i++) begin
				if (issue[i].valid) begin
					check_lane(i);
				end
			end
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Registers limited to x0..x7 so lanes collide often
	function automatic logic [31:0] rand_inst();
		logic [31:0] word;
		rng  = xorshift(rng);
		word = rng & 32'hfe73_f3ff;
		return {word[31:7], OPC_TAB[int'(rng[31:24]) % 10]};
	endfunction

	// Expected issue record from the RV32I encoding tables
	function automatic issue_t ref_decode(input logic [31:0] inst, input logic [31:0] pc,
		output logic [1:0] reads);
		issue_t r;
		r        = '0;
		r.valid  = 1'b1;
		r.pc     = pc;
		r.op     = OP_ALU;
		r.rd     = inst[11:7];
		r.rs1    = inst[19:15];
		r.rs2    = inst[24:20];
		r.rd_vld = 1'b1;
		reads    = 2'b00;
		case (inst[6:0])
			OPC_LUI, OPC_AUIPC: begin
				r.op  = (inst[6:0] == OPC_LUI) ? OP_LUI : OP_AUIPC;
				r.imm = {inst[31:12], 12'h000};
			end
			OPC_JAL: begin
				r.op  = OP_JAL;
				r.imm = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
			end
			OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
				r.op  = (inst[6:0] == OPC_JALR) ? OP_JALR :
					(inst[6:0] == OPC_LOAD) ? OP_LOAD : OP_ALU;
				r.imm = 32'($signed(inst[31:20]));
				reads = 2'b01;
			end
			OPC_BRANCH: begin
				r.op     = OP_BRANCH;
				r.rd_vld = 1'b0;
				r.imm    = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
				reads    = 2'b11;
			end
			OPC_STORE: begin
				r.op     = OP_STORE;
				r.rd_vld = 1'b0;
				r.imm    = 32'($signed({inst[31:25], inst[11:7]}));
				reads    = 2'b11;
			end
			OPC_OP: begin
				reads = 2'b11;
			end
			default: begin
				r.rd_vld    = 1'b0;
				r.exception = 1'b1;
			end
		endcase
		if (r.rd == 5'd0) begin
			r.rd_vld = 1'b0;
		end
		return r;
	endfunction

	task automatic model_pair(input logic [31:0] pc, input logic [31:0] i0,
		input logic [31:0] i1);
		issue_t     d0;
		issue_t     d1;
		logic [1:0] r0;
		logic [1:0] r1;
		logic       together;
		d0 = ref_decode(i0, pc, r0);
		d1 = ref_decode(i1, pc + 32'd4, r1);
		// Lane 1 waits on an illegal lane 0 or on a read of its rd
		together = !d0.exception && !(d0.rd_vld &&
			((r1[0] && d1.rs1 == d0.rd) || (r1[1] && d1.rs2 == d0.rd)));
		exp_q.push_back(d0);
		exp_q.push_back(d1);
		pair_q.push_back(together);
		pair_q.push_back(together);
	endtask

	task automatic check_lane(input int lane);
		issue_t want;
		logic   paired;
		assert (exp_q.size() != 0) else begin
			$display("%s: lane %0d issued with nothing outstanding", test_name, lane);
			errors++;
			return;
		end
		want   = exp_q.pop_front();
		paired = pair_q.pop_front();
		assert (issue[lane] == want) else begin
			$display("Fail %s lane %0d: expected %h actual %h", test_name, lane, want,
				issue[lane]);
			errors++;
		end
		assert (issue[1 - lane].valid == paired) else begin
			$display("Fail %s lane %0d pairing: expected %0b actual %0b", test_name, lane,
				paired, issue[1 - lane].valid);
			errors++;
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s: %s", test_name, reason);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic send_pair(input logic [31:0] pc, input logic [31:0] i0,
		input logic [31:0] i1);
		int n;
		n = 0;
		@(negedge clk);
		while (credits == 0) begin
			fetch_valid = 1'b0;
			n++;
			if (n > LIMIT) begin
				abort_run("no credit came back from the decode stage");
			end
			@(negedge clk);
		end
		fetch_valid   = 1'b1;
		fetch.pc      = pc;
		fetch.inst[0] = i0;
		fetch.inst[1] = i1;
		model_pair(pc, i0, i1);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		@(negedge clk);
		fetch_valid = 1'b0;
		while (exp_q.size() != 0) begin
			n++;
			if (n > LIMIT) begin
				abort_run("instructions did not issue in time");
			end
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic check_credits(input int want);
		assert (credits == want) else begin
			$display("Fail %s credits: expected %0d actual %0d", test_name, want, credits);
			errors++;
		end
	endtask

	task automatic end_test();
		tests++;
		$display("%s finished with %0d errors", test_name, errors - err_at_start);
		err_at_start = errors;
	endtask

	task automatic test_reset();
		test_name = "reset";
		@(negedge clk);
		assert (!issue[0].valid && !issue[1].valid) else begin
			$display("Fail reset issue valid: expected 00 actual %b%b", issue[1].valid,
				issue[0].valid);
			errors++;
		end
		assert (credit_return == '0) else begin
			$display("Fail reset credit_return: expected 0 actual %0d", credit_return);
			errors++;
		end
		check_credits(BUF_DEPTH);
		end_test();
	endtask

	task automatic test_pairs();
		// addi x5,x1,12 with lw x6,-8(x2)
		test_name = "independent";
		send_pair(32'h0000_1000, 32'h00c0_8293, 32'hff81_2303);
		wait_drain();
		end_test();
		// add x7,x5,x3 reads x5, then the same through x0
		test_name = "dependency";
		send_pair(32'h0000_1100, 32'h0010_8293, 32'h0032_83b3);
		send_pair(32'h0000_1108, 32'h0010_8013, 32'h0030_03b3);
		wait_drain();
		end_test();
		test_name = "illegal";
		send_pair(32'h0000_1200, 32'hffff_ffff, 32'h0030_0413);
		send_pair(32'h0000_1208, 32'h1234_54b7, 32'h0000_007f);
		wait_drain();
		end_test();
	endtask

	task automatic test_stream();
		logic [31:0] pc;
		logic [31:0] i0;
		logic [31:0] i1;
		test_name = "credit stream";
		for (int k = 0; k < 40; k++) begin
			rng = xorshift(rng);
			pc  = {rng[31:3], 3'b000};
			i0  = rand_inst();
			i1  = rand_inst();
			send_pair(pc, i0, i1);
		end
		wait_drain();
		check_credits(BUF_DEPTH);
		end_test();
	endtask

	task automatic test_flush();
		int dropped;
		test_name = "flush";
		for (int k = 0; k < BUF_DEPTH; k++) begin
			send_pair(32'h0000_2000 + 32'(8 * k), 32'h0010_8293, 32'h0052_8333);
		end
		@(negedge clk);
		fetch_valid = 1'b0;
		flush       = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		// Outstanding pairs, a half-issued head counts as one
		dropped = (exp_q.size() + 1) / 2;
		exp_q.delete();
		pair_q.delete();
		assert (flush_credits == dropped) else begin
			$display("Fail flush credit_return: expected %0d actual %0d", dropped,
				flush_credits);
			errors++;
		end
		check_credits(BUF_DEPTH);
		repeat (4) @(negedge clk);
		// beq x1,x2,16 with sw x3,4(x4)
		send_pair(32'h0000_3000, 32'h0020_8863, 32'h0032_2223);
		wait_drain();
		check_credits(BUF_DEPTH);
		end_test();
	endtask

	initial begin
		int n;
		fetch_valid  = 1'b0;
		fetch        = '0;
		flush        = 1'b0;
		rng          = 32'h081c4087;
		errors       = 0;
		err_at_start = 0;
		tests        = 0;
		test_name    = "setup";
		n            = 0;
		while (rst_n !== 1'b1) begin
			n++;
			if (n > LIMIT) begin
				abort_run("reset was never released");
			end
			@(negedge clk);
		end
		test_reset();
		test_pairs();
		test_stream();
		test_flush();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
//////////////////////////////
// Testbench clock and reset.
// 20 ns clock, reset low for 8 cycles.
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire
